//--- files.f
hw/dbg_pkg.sv
hw/dbg_ctrl_fsm.sv
hw/dbg_event_counter.sv
hw/hs_sticky_flags.sv
hw/sppe_capture.sv
hw/dbg_readout.sv
hw/gat_debugger.sv
bench/tb_gat_debugger.sv

//--- Bender.yml
package:
  name: gat_debugger

sources:
  - files:
      - hw/dbg_pkg.sv
      - hw/dbg_ctrl_fsm.sv
      - hw/dbg_event_counter.sv
      - hw/hs_sticky_flags.sv
      - hw/sppe_capture.sv
      - hw/dbg_readout.sv
      - hw/gat_debugger.sv
  - target: test
    files:
      - bench/tb_gat_debugger.sv

//--- bench/tb_gat_debugger.sv
`timescale 1ns/100ps

module tb_gat_debugger;

  import dbg_pkg::*;

  logic                              clk;
  logic                              rst_n;
  logic                              arm;
  logic                              clear;
  logic [DBG_W-1:0]                  count_limit;
  stage_hs_t                         hs;
  logic                              feat_ena;
  logic [FEAT_ADDR_W-1:0]            feat_addr;
  logic [WH_ADDR_W-1:0]              wh_addr;
  logic [SPPE_LANES-1:0][SPPE_W-1:0] sppe;
  rd_sel_e                           rd_sel;
  logic [DBG_W-1:0]                  rd_data;
  logic [31:0]                       lfsr;
  logic [DBG_W-1:0]                  limit_val;
  int                                waited;
  dbg_status_t                       st;

  // Reference model registers.
  dbg_state_e        m_state;
  stage_hs_t         m_hs;
  logic              m_ena;
  logic              m_over;
  logic [SPPE_W-1:0] m_cap_a;
  logic [SPPE_W-1:0] m_cap_b;
  logic [DBG_W-1:0]  m_count;
  logic              m_hit;
  dbg_status_t       m_status;
  logic [DBG_W-1:0]  exp_now;
  logic [DBG_W-1:0]  exp_rd;
  rd_sel_e           sel_q;

  always #4 clk = ~clk;

  gat_debugger gat_debugger_i (
    .clk, .rst_n, .arm_i(arm), .clear_i(clear), .count_limit_i(count_limit), .hs_i(hs),
    .feat_ena_i(feat_ena), .feat_addr_i(feat_addr), .wh_addr_i(wh_addr), .sppe_i(sppe),
    .rd_sel_i(rd_sel), .rd_data_o(rd_data)
  );

  // ============================================================
  // Stimulus.
  // ============================================================
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  task drive_random(input logic new_sel);
    logic [31:0]                       r;
    logic [SPPE_LANES-1:0][SPPE_W-1:0] lanes;
    r = take_bits(8);
    hs <= r[7:0];
    r = take_bits(1);
    feat_ena <= r[0];
    // Straddles the feature address limit.
    r = take_bits(3);
    feat_addr <= FEAT_ADDR_LIMIT - 16'd4 + r[15:0];
    r = take_bits(2);
    if (r[1:0] == 2'd0) begin
      wh_addr <= WH_TRIGGER_A;
    end else if (r[1:0] == 2'd1) begin
      wh_addr <= WH_TRIGGER_B;
    end else begin
      r = take_bits(5);
      wh_addr <= r[WH_ADDR_W-1:0];
    end
    for (int l = 0; l < SPPE_LANES; l++) begin
      r = take_bits(SPPE_W);
      lanes[l] = r[SPPE_W-1:0];
    end
    sppe  <= lanes;
    arm   <= 1'b0;
    clear <= 1'b0;
    if (new_sel) begin
      r = take_bits(3);
      if (r[2:0] > 3'd5) begin
        r[2:0] = r[2:0] - 3'd4;
      end
      rd_sel <= rd_sel_e'(r[2:0]);
    end
  endtask

  task run_random(input int n);
    repeat (n) begin
      @(posedge clk);
      drive_random(1'b1);
    end
  endtask

  task pulse(input logic do_arm, input logic do_clear);
    @(posedge clk);
    drive_random(1'b0);
    arm   <= do_arm;
    clear <= do_clear;
  endtask

  // ============================================================
  // Reporting and compare tasks.
  // ============================================================
  task report_mismatch(input string what, input logic [DBG_W-1:0] exp,
                       input logic [DBG_W-1:0] act);
    $display("** Error at %0t: %s mismatch, expected %h, got %h", $time, what, exp, act);
    $display("TESTBENCH FAILED");
    $fatal(1, "Wrong %s.", what);
  endtask

  task report_timeout(input string what);
    $display("Timeout: %s.", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "Timeout.");
  endtask

  task check_status(input dbg_status_t exp, input dbg_status_t act);
    if (act !== exp) report_mismatch("status word", exp, act);
  endtask

  task check_capture(input logic [SPPE_W-1:0] exp, input logic [SPPE_W-1:0] act);
    if (act !== exp) report_mismatch("capture word", DBG_W'(exp), DBG_W'(act));
  endtask

  task check_word(input logic [DBG_W-1:0] exp, input logic [DBG_W-1:0] act);
    if (act !== exp) report_mismatch("debug word", exp, act);
  endtask

  // ============================================================
  // Reference model with two edges from input to rd_data.
  // ============================================================
  assign m_hit = (count_limit != '0) && (m_count == count_limit);

  always_comb begin
    m_status           = '0;
    m_status.hs_seen   = m_hs;
    m_status.feat_ena  = m_ena;
    m_status.addr_over = m_over;
    m_status.frozen    = (m_state == FROZEN);
    m_status.armed     = (m_state == ARMED);
    case (rd_sel)
      ID:        exp_now = 32'd12;
      STATUS:    exp_now = m_status;
      CAPTURE_A: exp_now = DBG_W'(m_cap_a);
      CAPTURE_B: exp_now = DBG_W'(m_cap_b);
      COUNT:     exp_now = m_count;
      BUILD:     exp_now = 32'd19310;
      default:   exp_now = '0;
    endcase
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_state <= IDLE;
      m_hs    <= '0;
      m_ena   <= 1'b0;
      m_over  <= 1'b0;
      m_cap_a <= '0;
      m_cap_b <= '0;
      m_count <= '0;
      exp_rd  <= '0;
      sel_q   <= STATUS;
    end else begin
      exp_rd <= exp_now;
      sel_q  <= rd_sel;
      if (clear) begin
        m_state <= IDLE;
        m_hs    <= '0;
        m_ena   <= 1'b0;
        m_over  <= 1'b0;
        m_cap_a <= '0;
        m_cap_b <= '0;
        m_count <= '0;
      end else begin
        if (m_state == IDLE && arm) m_state <= ARMED;
        if (m_state == ARMED && m_hit) m_state <= FROZEN;
        if (m_state == ARMED) begin
          m_hs   <= m_hs | hs;
          m_ena  <= m_ena | feat_ena;
          m_over <= m_over | (feat_ena && feat_addr >= FEAT_ADDR_LIMIT);
          if (hs.spmm_rdy && wh_addr == WH_TRIGGER_A) m_cap_a <= sppe[SPPE_CAPTURE_LANE];
          if (hs.spmm_rdy && wh_addr == WH_TRIGGER_B) m_cap_b <= sppe[SPPE_CAPTURE_LANE];
          if (hs.sm_vld && !m_hit) m_count <= m_count + 1'b1;
        end
      end
    end
  end

  // Outputs are settled at the falling edge.
  always @(negedge clk) begin
    if (rst_n) begin
      case (sel_q)
        STATUS: check_status(exp_rd, rd_data);
        CAPTURE_A, CAPTURE_B: begin
          check_capture(exp_rd[SPPE_W-1:0], rd_data[SPPE_W-1:0]);
          check_word(exp_rd, rd_data);
        end
        default: check_word(exp_rd, rd_data);
      endcase
    end
  end

  initial begin
    repeat (20000) @(posedge clk);
    report_timeout("the run went past its cycle budget");
  end

  // ============================================================
  // Test sequence.
  // ============================================================
  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    arm         = 1'b0;
    clear       = 1'b0;
    count_limit = '0;
    hs          = '0;
    feat_ena    = 1'b0;
    feat_addr   = '0;
    wh_addr     = '0;
    sppe        = '0;
    rd_sel      = ID;
    lfsr        = 32'he745_27e5;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Every select value straight after reset.
    for (int s = 0; s < 8; s++) begin
      @(posedge clk);
      rd_sel <= rd_sel_e'(s);
    end
    @(posedge clk);
    run_random(40);

    pulse(1'b1, 1'b0);
    run_random(300);

    // Clear wins over arm in the same cycle in ARMED and in IDLE.
    pulse(1'b1, 1'b1);
    run_random(10);
    pulse(1'b1, 1'b1);
    run_random(10);

    @(posedge clk);
    drive_random(1'b0);
    limit_val = take_bits(4) + 32'd1;
    count_limit <= limit_val;
    rd_sel <= STATUS;
    pulse(1'b1, 1'b0);
    waited = 0;
    st     = '0;
    while (!st.frozen) begin
      @(posedge clk);
      drive_random(1'b0);
      @(negedge clk);
      st     = rd_data;
      waited = waited + 1;
      if (waited > 500 && !st.frozen) report_timeout("frozen status bit never set");
    end
    run_random(100);

    @(posedge clk);
    drive_random(1'b0);
    rd_sel <= COUNT;
    @(posedge clk);
    drive_random(1'b0);
    @(negedge clk);
    check_word(limit_val, rd_data);

    pulse(1'b0, 1'b1);
    run_random(20);
    pulse(1'b1, 1'b0);
    run_random(100);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

//--- hw/gat_debugger.sv
`timescale 1ns/100ps

module gat_debugger (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 arm_i,
  input  logic                                                 clear_i,
  input  logic [dbg_pkg::DBG_W-1:0]                            count_limit_i,
  input  dbg_pkg::stage_hs_t                                   hs_i,
  input  logic                                                 feat_ena_i,
  input  logic [dbg_pkg::FEAT_ADDR_W-1:0]                      feat_addr_i,
  input  logic [dbg_pkg::WH_ADDR_W-1:0]                        wh_addr_i,
  input  logic [dbg_pkg::SPPE_LANES-1:0][dbg_pkg::SPPE_W-1:0]  sppe_i,
  input  dbg_pkg::rd_sel_e                                     rd_sel_i,
  output logic [dbg_pkg::DBG_W-1:0]                            rd_data_o
);

  import dbg_pkg::*;

  logic              rec_en;
  logic              clr;
  logic              limit_hit;
  dbg_state_e        state;
  stage_hs_t         hs_seen;
  logic              feat_ena_seen;
  logic              feat_addr_over;
  logic [SPPE_W-1:0] cap_a;
  logic [SPPE_W-1:0] cap_b;
  logic [DBG_W-1:0]  count;

  // ============================================================
  // Control.
  // ============================================================
  dbg_ctrl_fsm ctrl_fsm_i (
    .clk, .rst_n, .arm_i, .clear_i, .limit_hit_i(limit_hit),
    .rec_en_o(rec_en), .clr_o(clr), .state_o(state)
  );

  dbg_event_counter event_counter_i (
    .clk, .rst_n, .rec_en_i(rec_en), .clr_i(clr), .sm_vld_i(hs_i.sm_vld),
    .limit_i(count_limit_i), .count_o(count), .limit_hit_o(limit_hit)
  );

  // ============================================================
  // Recording and readout.
  // ============================================================
  hs_sticky_flags sticky_flags_i (
    .clk, .rst_n, .rec_en_i(rec_en), .clr_i(clr), .hs_i, .feat_ena_i, .feat_addr_i,
    .hs_seen_o(hs_seen), .feat_ena_seen_o(feat_ena_seen), .feat_addr_over_o(feat_addr_over)
  );

  sppe_capture sppe_capture_i (
    .clk, .rst_n, .rec_en_i(rec_en), .clr_i(clr), .spmm_rdy_i(hs_i.spmm_rdy),
    .wh_addr_i, .sppe_i, .cap_a_o(cap_a), .cap_b_o(cap_b)
  );

  dbg_readout readout_i (
    .clk, .rst_n, .rd_sel_i, .state_i(state), .hs_seen_i(hs_seen),
    .feat_ena_seen_i(feat_ena_seen), .feat_addr_over_i(feat_addr_over),
    .cap_a_i(cap_a), .cap_b_i(cap_b), .count_i(count), .rd_data_o
  );

endmodule

//--- hw/dbg_readout.sv
`timescale 1ns/100ps

module dbg_readout (
  input  logic                       clk,
  input  logic                       rst_n,
  input  dbg_pkg::rd_sel_e           rd_sel_i,
  input  dbg_pkg::dbg_state_e        state_i,
  input  dbg_pkg::stage_hs_t         hs_seen_i,
  input  logic                       feat_ena_seen_i,
  input  logic                       feat_addr_over_i,
  input  logic [dbg_pkg::SPPE_W-1:0] cap_a_i,
  input  logic [dbg_pkg::SPPE_W-1:0] cap_b_i,
  input  logic [dbg_pkg::DBG_W-1:0]  count_i,
  output logic [dbg_pkg::DBG_W-1:0]  rd_data_o
);

  import dbg_pkg::*;

  dbg_status_t status;

  always_comb begin
    status           = '0;
    status.hs_seen   = hs_seen_i;
    status.feat_ena  = feat_ena_seen_i;
    status.addr_over = feat_addr_over_i;
    status.frozen    = (state_i == FROZEN);
    status.armed     = (state_i == ARMED);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_o <= '0;
    end else begin
      case (rd_sel_i)
        ID:        rd_data_o <= H_NUM_SPARSE_DATA;
        STATUS:    rd_data_o <= status;
        CAPTURE_A: rd_data_o <= {{(DBG_W-SPPE_W){1'b0}}, cap_a_i};
        CAPTURE_B: rd_data_o <= {{(DBG_W-SPPE_W){1'b0}}, cap_b_i};
        COUNT:     rd_data_o <= count_i;
        BUILD:     rd_data_o <= BUILD_ID;
        default:   rd_data_o <= '0;
      endcase
    end
  end

  a_sel_named : assert property (@(posedge clk) disable iff (!rst_n)
    rd_sel_i inside {ID, STATUS, CAPTURE_A, CAPTURE_B, COUNT, BUILD})
    else $warning("Unnamed readout select value %0d.", rd_sel_i);

endmodule

//--- hw/sppe_capture.sv
`timescale 1ns/100ps

module sppe_capture (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 rec_en_i,
  input  logic                                                 clr_i,
  input  logic                                                 spmm_rdy_i,
  input  logic [dbg_pkg::WH_ADDR_W-1:0]                        wh_addr_i,
  input  logic [dbg_pkg::SPPE_LANES-1:0][dbg_pkg::SPPE_W-1:0]  sppe_i,
  output logic [dbg_pkg::SPPE_W-1:0]                           cap_a_o,
  output logic [dbg_pkg::SPPE_W-1:0]                           cap_b_o
);

  import dbg_pkg::*;

  logic [SPPE_W-1:0] cap_a_q;
  logic [SPPE_W-1:0] cap_b_q;
  logic [SPPE_W-1:0] lane;
  logic              hit_a;
  logic              hit_b;

  assign lane  = sppe_i[SPPE_CAPTURE_LANE];
  assign hit_a = rec_en_i && spmm_rdy_i && (wh_addr_i == WH_TRIGGER_A);
  assign hit_b = rec_en_i && spmm_rdy_i && (wh_addr_i == WH_TRIGGER_B);

  // Last hit wins.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else if (clr_i) begin
      cap_a_q <= '0;
      cap_b_q <= '0;
    end else begin
      if (hit_a) begin
        cap_a_q <= lane;
      end
      if (hit_b) begin
        cap_b_q <= lane;
      end
    end
  end

  assign cap_a_o = cap_a_q;
  assign cap_b_o = cap_b_q;

endmodule

//--- hw/hs_sticky_flags.sv
`timescale 1ns/100ps

module hs_sticky_flags (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rec_en_i,
  input  logic                            clr_i,
  input  dbg_pkg::stage_hs_t              hs_i,
  input  logic                            feat_ena_i,
  input  logic [dbg_pkg::FEAT_ADDR_W-1:0] feat_addr_i,
  output dbg_pkg::stage_hs_t              hs_seen_o,
  output logic                            feat_ena_seen_o,
  output logic                            feat_addr_over_o
);

  import dbg_pkg::*;

  stage_hs_t hs_seen_q;
  logic      feat_ena_q;
  logic      addr_over_q;
  logic      addr_over_now;

  // Only a real write can go past the limit.
  assign addr_over_now = feat_ena_i && (feat_addr_i >= FEAT_ADDR_LIMIT);

  // ============================================================
  // Sticky flags that only clr resets.
  // ============================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hs_seen_q   <= '0;
      feat_ena_q  <= 1'b0;
      addr_over_q <= 1'b0;
    end else if (clr_i) begin
      hs_seen_q   <= '0;
      feat_ena_q  <= 1'b0;
      addr_over_q <= 1'b0;
    end else if (rec_en_i) begin
      hs_seen_q   <= hs_seen_q | hs_i;
      feat_ena_q  <= feat_ena_q | feat_ena_i;
      addr_over_q <= addr_over_q | addr_over_now;
    end
  end

  assign hs_seen_o        = hs_seen_q;
  assign feat_ena_seen_o  = feat_ena_q;
  assign feat_addr_over_o = addr_over_q;

endmodule

//--- hw/dbg_event_counter.sv
`timescale 1ns/100ps

module dbg_event_counter (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      rec_en_i,
  input  logic                      clr_i,
  input  logic                      sm_vld_i,
  input  logic [dbg_pkg::DBG_W-1:0] limit_i,
  output logic [dbg_pkg::DBG_W-1:0] count_o,
  output logic                      limit_hit_o
);

  import dbg_pkg::*;

  logic [DBG_W-1:0] count_q;

  // A zero limit means count without end.
  assign limit_hit_o = (limit_i != '0) && (count_q == limit_i);

  // Holding at the limit covers the cycle before the FSM freezes.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q <= '0;
    end else if (clr_i) begin
      count_q <= '0;
    end else if (rec_en_i && sm_vld_i && !limit_hit_o) begin
      count_q <= count_q + 1'b1;
    end
  end

  assign count_o = count_q;

  a_count_idle : assert property (@(posedge clk) disable iff (!rst_n)
    !rec_en_i && !clr_i |=> $stable(count_q));

endmodule

//--- hw/dbg_ctrl_fsm.sv
`timescale 1ns/100ps

module dbg_ctrl_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                arm_i,
  input  logic                clear_i,
  input  logic                limit_hit_i,
  output logic                rec_en_o,
  output logic                clr_o,
  output dbg_pkg::dbg_state_e state_o
);

  import dbg_pkg::*;

  dbg_state_e state_q;
  dbg_state_e state_d;

  // Clear beats arm when both arrive together.
  always_comb begin
    state_d = state_q;
    if (clear_i) begin
      state_d = IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (arm_i) begin
            state_d = ARMED;
          end
        end
        ARMED: begin
          if (limit_hit_i) begin
            state_d = FROZEN;
          end
        end
        FROZEN: begin
          state_d = FROZEN;
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign rec_en_o = (state_q == ARMED);
  assign clr_o    = clear_i;
  assign state_o  = state_q;

  a_state_legal : assert property (@(posedge clk) disable iff (!rst_n)
    state_q inside {IDLE, ARMED, FROZEN});

  // Only a clear takes the monitor out of FROZEN.
  a_frozen_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == FROZEN) && !clear_i |=> (state_q == FROZEN));

endmodule

//--- hw/dbg_pkg.sv
package dbg_pkg;

  // ============================================================
  // Widths and fixed values.
  // ============================================================
  localparam int DBG_W             = 32;
  localparam int SPPE_LANES        = 16;
  localparam int SPPE_W            = 12;
  localparam int SPPE_CAPTURE_LANE = 2;
  localparam int WH_ADDR_W         = 14;
  localparam int FEAT_ADDR_W       = 16;

  localparam logic [WH_ADDR_W-1:0]   WH_TRIGGER_A    = 14'd10;
  localparam logic [WH_ADDR_W-1:0]   WH_TRIGGER_B    = 14'd20;
  localparam logic [FEAT_ADDR_W-1:0] FEAT_ADDR_LIMIT = 16'd43328;

  // Identification words.
  localparam logic [DBG_W-1:0] H_NUM_SPARSE_DATA = 32'd12;
  localparam logic [DBG_W-1:0] BUILD_ID          = 32'd19310;

  // ============================================================
  // Types.
  // ============================================================
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_hs_t;

  typedef struct packed {
    stage_hs_t   hs_seen;
    logic        feat_ena;
    logic        addr_over;
    logic        frozen;
    logic        armed;
    logic [19:0] pad;
  } dbg_status_t;

  typedef enum logic [1:0] {IDLE = 2'd0, ARMED = 2'd1, FROZEN = 2'd2} dbg_state_e;

  typedef enum logic [2:0] {
    ID = 3'd0, STATUS = 3'd1, CAPTURE_A = 3'd2, CAPTURE_B = 3'd3, COUNT = 3'd4, BUILD = 3'd5
  } rd_sel_e;

endpackage
